//--- common/spi_rx_pkg.sv
// SPI receive package with the captured word type, AXI4-Lite bus structs and register map
package spi_rx_pkg;

    localparam int LOST_W = 16;                    // Lost-word counter width

    // One captured serial word as it sits in the FIFO and on the bus
    typedef struct packed {
        logic [3:0]  src_id;                       // Source tag from SOURCE_ID
        logic [11:0] frame;                        // Frame number modulo 4096
        logic [15:0] data;                         // Right-aligned serial payload
    } rx_word_t;

    // Host to slave channel signals
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;                        // Accepted, never used
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Slave to host channel signals
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // Register offsets
    localparam logic [7:0] REG_RESET  = 8'h00;     // Any write issues a soft reset
    localparam logic [7:0] REG_CTRL   = 8'h04;     // Bit 0 capture enable
    localparam logic [7:0] REG_LOST   = 8'h08;     // Lost-word count, read only
    localparam logic [7:0] REG_STATUS = 8'h0C;     // Bit 0 empty, level from bit 16
    localparam logic [7:0] REG_DATA   = 8'h10;     // Read pops one word

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hw/spi_rx_deframer/spi_rx_deframer.sv
// Serial deframer that samples SDI under SEN and builds tagged words with frame and loss counts
module spi_rx_deframer #(
    parameter logic [3:0] SOURCE_ID = 4'd1
) (
    input  logic                          SCLK,
    input  logic                          RST,
    input  logic                          sdi,
    input  logic                          sen,
    input  logic                          capture_en,
    input  logic                          clear,
    input  logic                          full,
    output logic                          push,
    output spi_rx_pkg::rx_word_t          word,
    output logic [spi_rx_pkg::LOST_W-1:0] lost_cnt
);
    import spi_rx_pkg::*;

    logic        sen_dly;
    logic        sen_fall;
    logic        take_bit;
    logic        full_done;
    logic        part_done;
    logic        word_done;
    logic [3:0]  bit_cnt;
    logic [15:0] shift_q;
    logic [15:0] next_data;
    logic [11:0] frame_cnt;

    assign sen_fall  = sen_dly && !sen;                     // End of a frame
    assign take_bit  = sen && capture_en;
    assign full_done = take_bit && (bit_cnt == 4'd15);      // 16th bit arrives now
    assign part_done = sen_fall && capture_en && (bit_cnt != 4'd0);
    assign word_done = full_done || part_done;

    // A full word takes the current bit, a partial one is already right-aligned
    assign next_data = full_done ? {shift_q[14:0], sdi} : shift_q;

    always_ff @(posedge SCLK) begin
        if (RST) begin
            sen_dly <= 1'b0;
        end else begin
            sen_dly <= sen;
        end
    end

    // Shift register and bit counter, emptied after each completed word
    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            bit_cnt <= 4'd0;
            shift_q <= 16'd0;
        end else if (full_done || sen_fall) begin
            bit_cnt <= 4'd0;
            shift_q <= 16'd0;                               // Zeros above a short word
        end else if (take_bit) begin
            bit_cnt <= bit_cnt + 4'd1;
            shift_q <= {shift_q[14:0], sdi};                // MSB first
        end
    end

    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            frame_cnt <= 12'd0;
        end else if (sen_fall && capture_en) begin
            frame_cnt <= frame_cnt + 12'd1;                 // Wraps at 4096
        end
    end

    // Full is sampled at the completion edge; pushes are at least two cycles apart,
    // so the FIFO has already counted the previous push by then
    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            push     <= 1'b0;
            lost_cnt <= '0;
        end else begin
            push <= word_done && !full;
            if (word_done && full && (lost_cnt != {LOST_W{1'b1}})) begin
                lost_cnt <= lost_cnt + 1'b1;                // Saturating
            end
        end
    end

    always_ff @(posedge SCLK) begin
        if (word_done) begin
            word.src_id <= SOURCE_ID;
            word.frame  <= frame_cnt;                       // Number of the current frame
            word.data   <= next_data;
        end
    end

    // The FIFO must never see a push while it reports full
    a_push_not_full: assert property (@(posedge SCLK) disable iff (RST)
        push |-> !full);

endmodule

//--- hw/word_fifo.sv
// Synchronous show-ahead FIFO for any payload type with a fill level output
module word_fifo #(
    parameter type item_t = logic [31:0],
    parameter int  DEPTH  = 16
) (
    input  logic                         SCLK,
    input  logic                         RST,
    input  logic                         clear,
    input  logic                         push,
    input  item_t                        wr_item,
    input  logic                         pop,
    output item_t                        rd_item,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   level
);
    localparam int AW = $clog2(DEPTH);

    item_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic           do_push;
    logic           do_pop;

    assign full    = (level == DEPTH[$clog2(DEPTH+1)-1:0]);
    assign empty   = (level == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rd_item = mem[rd_ptr];                           // Head shown ahead of the pop

    always_ff @(posedge SCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_item;
        end
    end

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge SCLK) begin
        if (RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;                    // Both or neither
            endcase
        end
    end

    // The writer and the reader both honour the flags they were given
    a_no_push_full: assert property (@(posedge SCLK) disable iff (RST)
        push |-> !full);

    a_no_pop_empty: assert property (@(posedge SCLK) disable iff (RST)
        pop |-> !empty);

endmodule

//--- hw/spi_rx_regs/spi_rx_regs.sv
// AXI4-Lite register block with capture control, soft reset, status, lost count and data pop
module spi_rx_regs #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                              SCLK,
    input  logic                              RST,
    input  spi_rx_pkg::axil_req_t             axil_req,
    output spi_rx_pkg::axil_rsp_t             axil_rsp,
    output logic                              capture_en,
    output logic                              clear,
    input  logic [spi_rx_pkg::LOST_W-1:0]     lost_cnt,
    input  spi_rx_pkg::rx_word_t              rd_word,
    input  logic                              empty,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   level,
    output logic                              pop
);
    import spi_rx_pkg::*;

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    logic        wr_accept;
    logic        rd_accept;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic [1:0]  wr_resp_nxt;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;
    logic [31:0] rd_data_nxt;
    logic [1:0]  rd_resp_nxt;
    logic [31:0] status_word;

    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_accept = axil_req.arvalid && !rvalid_q;

    // Head word leaves the FIFO in the acceptance cycle
    assign pop = rd_accept && (axil_req.araddr == REG_DATA) && !empty;

    always_comb begin
        status_word                = 32'd0;
        status_word[0]             = empty;
        status_word[16 +: LEVEL_W] = level;
    end

    always_comb begin
        case (axil_req.awaddr)
            REG_RESET, REG_CTRL: wr_resp_nxt = RESP_OKAY;
            default:             wr_resp_nxt = RESP_SLVERR;     // Read only or unmapped
        endcase
    end

    always_comb begin
        rd_data_nxt = 32'd0;
        rd_resp_nxt = RESP_OKAY;
        case (axil_req.araddr)
            REG_RESET:  rd_data_nxt = 32'd0;
            REG_CTRL:   rd_data_nxt = {31'd0, capture_en};
            REG_LOST:   rd_data_nxt = 32'(lost_cnt);
            REG_STATUS: rd_data_nxt = status_word;
            REG_DATA: begin
                if (empty) begin
                    rd_resp_nxt = RESP_SLVERR;              // Nothing to pop
                end else begin
                    rd_data_nxt = rd_word;                  // src_id, frame, data
                end
            end
            default:    rd_resp_nxt = RESP_SLVERR;
        endcase
    end

    // Write channel and control register
    always_ff @(posedge SCLK) begin
        if (RST) begin
            bvalid_q   <= 1'b0;
            bresp_q    <= RESP_OKAY;
            capture_en <= 1'b0;
            clear      <= 1'b0;
        end else begin
            clear <= wr_accept && (axil_req.awaddr == REG_RESET);   // One-cycle pulse
            if (wr_accept) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_resp_nxt;
                if (axil_req.awaddr == REG_CTRL) begin
                    capture_en <= axil_req.wdata[0];
                end
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // Read channel
    always_ff @(posedge SCLK) begin
        if (RST) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge SCLK) begin
        if (rd_accept) begin
            rdata_q <= rd_data_nxt;                         // Held until the next accept
            rresp_q <= rd_resp_nxt;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = rd_accept;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    // Responses hold steady under host back-pressure
    a_r_stable: assert property (@(posedge SCLK) disable iff (RST)
        rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));

    a_b_stable: assert property (@(posedge SCLK) disable iff (RST)
        bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q));

endmodule

//--- hw/spi_rx_top.sv
// Serial capture top level joining the deframer, word FIFO and AXI4-Lite register block
module spi_rx_top #(
    parameter logic [3:0] SOURCE_ID  = 4'd1,
    parameter int         FIFO_DEPTH = 16
) (
    input  logic                  SCLK,
    input  logic                  RST,
    input  logic                  SDI,
    input  logic                  SEN,
    input  spi_rx_pkg::axil_req_t axil_req,
    output spi_rx_pkg::axil_rsp_t axil_rsp
);
    import spi_rx_pkg::*;

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    logic               push;
    logic               full;
    logic               pop;
    logic               empty;
    logic               capture_en;
    logic               clear;
    rx_word_t           wr_word;
    rx_word_t           rd_word;
    logic [LOST_W-1:0]  lost_cnt;
    logic [LEVEL_W-1:0] level;

    spi_rx_deframer #(
        .SOURCE_ID (SOURCE_ID)
    ) deframer_i (
        .SCLK       (SCLK),
        .RST        (RST),
        .sdi        (SDI),
        .sen        (SEN),
        .capture_en (capture_en),
        .clear      (clear),
        .full       (full),
        .push       (push),
        .word       (wr_word),
        .lost_cnt   (lost_cnt)
    );

    word_fifo #(
        .item_t (rx_word_t),
        .DEPTH  (FIFO_DEPTH)
    ) fifo_i (
        .SCLK    (SCLK),
        .RST     (RST),
        .clear   (clear),
        .push    (push),
        .wr_item (wr_word),
        .pop     (pop),
        .rd_item (rd_word),
        .full    (full),
        .empty   (empty),
        .level   (level)
    );

    spi_rx_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) regs_i (
        .SCLK       (SCLK),
        .RST        (RST),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .capture_en (capture_en),
        .clear      (clear),
        .lost_cnt   (lost_cnt),
        .rd_word    (rd_word),
        .empty      (empty),
        .level      (level),
        .pop        (pop)
    );

endmodule

//--- verification/spi_rx_clkgen.sv
// Clock and reset source for the serial capture testbench
module spi_rx_clkgen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 16
) (
    output logic SCLK,
    output logic RST
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        SCLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2) SCLK = ~SCLK;
        end
    end

    initial begin
        RST = 1'b1;                                             // Held from time zero
        repeat (RST_CYCLES) @(posedge SCLK);
        RST <= 1'b0;
    end

endmodule

//--- verification/spi_rx_tb.sv
// Testbench for the serial capture block with LFSR stimulus and a queue reference model
module spi_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import spi_rx_pkg::*;

    localparam logic [3:0] SRC_ID        = 4'd1;
    localparam int         FIFO_DEPTH    = 16;
    localparam int         CLK_PERIOD_NS = 100;
    localparam int         HS_LIMIT      = 64;                  // Cycles before a handshake gives up
    localparam int         FRAME_MAX     = 48;                  // 40 bits, fall, gap and settle
    localparam int         AXI_MAX       = 24;                  // One access with the longest hold
    localparam int         TOTAL_CYC     = 20 + (3 * FRAME_MAX + 2 * AXI_MAX)
                                         + 20 * (FRAME_MAX + 4 * AXI_MAX)
                                         + (6 * 72 + 18 * AXI_MAX)
                                         + (6 * FRAME_MAX + 25 * AXI_MAX)
                                         + (2 * FRAME_MAX + 8 * AXI_MAX)
                                         + (2 * FRAME_MAX + 12 * AXI_MAX);

    typedef logic [LOST_W-1:0] count_t;

    logic        SCLK;
    logic        RST;
    logic        sdi;
    logic        sen;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;

    logic [15:0] lfsr = 16'd26;
    rx_word_t    exp_q[$];                                      // Words the FIFO should hold
    count_t      exp_lost;
    logic [11:0] exp_frame;
    logic        cap_en;
    int          hold_bits = 3;                                 // Width of the random ready delay
    int          checks;
    int          errors;
    int          err_mark;
    int          tests_failed;

    spi_rx_clkgen #(
        .PERIOD_NS  (CLK_PERIOD_NS),
        .RST_CYCLES (16)
    ) clkgen_i (
        .SCLK (SCLK),
        .RST  (RST)
    );

    spi_rx_top #(
        .SOURCE_ID  (SRC_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .SCLK     (SCLK),
        .RST      (RST),
        .SDI      (sdi),
        .SEN      (sen),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) lfsr = lfsr ^ 16'hB400;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_bits(8) % (hi - lo + 1));
    endfunction

    // Reference model of one completed word
    function automatic void model_push(input logic [15:0] data);
        rx_word_t w;
        w.src_id = SRC_ID;
        w.frame  = exp_frame;
        w.data   = data;
        if (!cap_en) begin
            return;                                             // Capture off, bits ignored
        end
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back(w);
        end else if (exp_lost != '1) begin
            exp_lost = exp_lost + 1'b1;
        end
    endfunction

    task automatic check_word(input rx_word_t got, input rx_word_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR at %0d ns: %s got %h/%h/%h, expected %h/%h/%h", $time, what,
                     got.src_id, got.frame, got.data, want.src_id, want.frame, want.data);
        end
    endtask

    task automatic check_count(input count_t got, input count_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR at %0d ns: %s got %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR at %0d ns: %s got %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic send_frame(input int nbits);
        logic [15:0] acc;
        logic        b;
        int          k;
        int          gap;
        acc = '0;
        k   = 0;
        for (int i = 0; i < nbits; i++) begin
            b = (rand_bits(1) != 0);
            @(posedge SCLK);
            sen <= 1'b1;
            sdi <= b;
            acc = {acc[14:0], b};                               // MSB first
            k++;
            if (k == 16) begin
                model_push(acc);
                acc = '0;
                k   = 0;
            end
        end
        @(posedge SCLK);
        sen <= 1'b0;
        sdi <= 1'b0;
        if (k != 0) model_push(acc);                            // Short tail, zeros above
        if (cap_en) exp_frame = exp_frame + 12'd1;
        gap = int'(rand_bits(2));
        repeat (gap) @(posedge SCLK);
    endtask

    // SEN fall edge plus two cycles to reach the FIFO head
    task automatic let_words_land();
        repeat (3) @(posedge SCLK);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int hold;
        int n;
        hold = int'(rand_bits(hold_bits));
        @(posedge SCLK);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        axil_req.wvalid  <= 1'b1;
        n = 0;
        do begin
            @(negedge SCLK);
            n++;
        end while (!(axil_rsp.awready && axil_rsp.wready) && n < HS_LIMIT);
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            errors++;
            $display("Write to address %h was not accepted within %0d cycles", addr, HS_LIMIT);
        end
        @(posedge SCLK);                                        // Write taken here
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        do begin
            @(negedge SCLK);
            n++;
        end while (!axil_rsp.bvalid && n < HS_LIMIT);
        if (!axil_rsp.bvalid) begin
            errors++;
            $display("Write to address %h got no response within %0d cycles", addr, HS_LIMIT);
        end
        resp = axil_rsp.bresp;
        repeat (hold) begin
            @(negedge SCLK);
            if (!axil_rsp.bvalid || axil_rsp.bresp !== resp) begin
                errors++;
                $display("ERROR at %0d ns: write response moved while held off", $time);
            end
        end
        @(posedge SCLK);
        axil_req.bready <= 1'b1;
        @(posedge SCLK);                                        // Response handshake
        axil_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int hold;
        int n;
        hold = int'(rand_bits(hold_bits));
        @(posedge SCLK);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge SCLK);
            n++;
        end while (!axil_rsp.arready && n < HS_LIMIT);
        if (!axil_rsp.arready) begin
            errors++;
            $display("Read of address %h was not accepted within %0d cycles", addr, HS_LIMIT);
        end
        @(posedge SCLK);                                        // Address taken here
        axil_req.arvalid <= 1'b0;
        do begin
            @(negedge SCLK);
            n++;
        end while (!axil_rsp.rvalid && n < HS_LIMIT);
        if (!axil_rsp.rvalid) begin
            errors++;
            $display("Read of address %h got no response within %0d cycles", addr, HS_LIMIT);
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        repeat (hold) begin
            @(negedge SCLK);
            if (!axil_rsp.rvalid || axil_rsp.rdata !== data || axil_rsp.rresp !== resp) begin
                errors++;
                $display("ERROR at %0d ns: read of %h moved while held off", $time, addr);
            end
        end
        @(posedge SCLK);
        axil_req.rready <= 1'b1;
        @(posedge SCLK);                                        // Data handshake
        axil_req.rready <= 1'b0;
    endtask

    task automatic drain_words(input int n);
        rx_word_t    want;
        logic [31:0] data;
        logic [1:0]  resp;
        repeat (n) begin
            want = exp_q.pop_front();
            axi_read(REG_DATA, data, resp);
            check_resp(resp, RESP_OKAY, "DATA response");
            check_word(rx_word_t'(data), want, "DATA word");
        end
    endtask

    task automatic check_status();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(REG_STATUS, data, resp);
        check_resp(resp, RESP_OKAY, "STATUS response");
        check_count(count_t'(data[31:16]), count_t'(exp_q.size()), "STATUS level");
        check_count(count_t'(data[0]), count_t'(exp_q.size() == 0), "STATUS empty");
    endtask

    task automatic check_lost();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(REG_LOST, data, resp);
        check_resp(resp, RESP_OKAY, "LOST response");
        check_count(count_t'(data), exp_lost, "LOST count");
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == err_mark) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        sdi       <= 1'b0;
        sen       <= 1'b0;
        axil_req  <= '0;
        exp_lost  = '0;
        exp_frame = '0;
        cap_en    = 1'b0;
        checks    = 0;
        errors    = 0;
        err_mark  = 0;
        tests_failed = 0;
        @(posedge SCLK);
        while (RST !== 1'b0) @(posedge SCLK);

        repeat (3) send_frame(rand_range(1, 40));
        let_words_land();
        check_status();
        check_lost();
        finish_test(1, "capture disabled");

        axi_write(REG_CTRL, 32'd1, resp);
        check_resp(resp, RESP_OKAY, "CTRL write response");
        cap_en = 1'b1;
        repeat (20) begin
            send_frame(rand_range(1, 40));
            let_words_land();
            drain_words(exp_q.size());
        end
        check_status();
        finish_test(2, "random frames");

        repeat (6) send_frame(64);                              // 24 full words
        let_words_land();
        check_status();
        drain_words(exp_q.size());
        check_lost();
        axi_read(REG_DATA, data, resp);
        check_resp(resp, RESP_SLVERR, "empty DATA response");
        check_word(rx_word_t'(data), '0, "empty DATA value");
        finish_test(3, "overflow");

        repeat (3) begin
            repeat (2) send_frame(rand_range(1, 40));
            let_words_land();
            check_status();
            drain_words(exp_q.size() / 2);
            check_status();
        end
        drain_words(exp_q.size());
        check_status();
        finish_test(4, "fill level");

        send_frame(rand_range(17, 40));
        let_words_land();
        axi_write(REG_RESET, rand_bits(32), resp);
        check_resp(resp, RESP_OKAY, "RESET write response");
        exp_q.delete();
        exp_lost  = '0;
        exp_frame = '0;
        check_status();
        check_lost();
        send_frame(20);
        let_words_land();
        axi_read(REG_DATA, data, resp);
        check_resp(resp, RESP_OKAY, "DATA response after soft reset");
        check_count(count_t'(data[27:16]), count_t'(0), "frame after soft reset");
        check_word(rx_word_t'(data), exp_q.pop_front(), "first word after soft reset");
        drain_words(exp_q.size());
        finish_test(5, "soft reset");

        hold_bits = 4;                                          // Longer host stalls
        repeat (2) send_frame(40);
        let_words_land();
        drain_words(exp_q.size());
        hold_bits = 3;
        axi_write(REG_LOST, 32'hFFFF, resp);
        check_resp(resp, RESP_SLVERR, "LOST write response");
        axi_write(8'h40, 32'd1, resp);
        check_resp(resp, RESP_SLVERR, "unmapped write response");
        axi_read(8'h44, data, resp);
        check_resp(resp, RESP_SLVERR, "unmapped read response");
        check_lost();
        finish_test(6, "back-pressure and errors");

        $display("Tests run 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Twice the longest expected run
    initial begin
        #(2 * TOTAL_CYC * CLK_PERIOD_NS);
        $display("Timeout: the tests did not finish within %0d clock cycles", 2 * TOTAL_CYC);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- spi_rx_top.f
common/spi_rx_pkg.sv
hw/spi_rx_deframer/spi_rx_deframer.sv
hw/word_fifo.sv
hw/spi_rx_regs/spi_rx_regs.sv
hw/spi_rx_top.sv
verification/spi_rx_clkgen.sv
verification/spi_rx_tb.sv

//--- Makefile
# Verilator build and run of the serial capture testbench

VERILATOR ?= verilator
TOP       ?= spi_rx_tb
FLIST     ?= spi_rx_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check for a pass"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, FLIST, BUILD_DIR, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
